//--- hdl/rx_hp_pkg.sv
/*
 * Shared widths and the worker state encoding for the receive header scheduler
 * Destination masks depend on WORKERS and stay plain vectors in each module
 */

`default_nettype none

package rx_hp_pkg;

    //////////////////////////////////////////////////////////////
    // Descriptor fields
    //////////////////////////////////////////////////////////////

    // Descriptor identifier, unique while in flight
    typedef logic [7:0] tag_t;

    // Processing length, a worker stays busy for len+1 cycles
    typedef logic [3:0] len_t;

    //////////////////////////////////////////////////////////////
    // Worker state machine
    //////////////////////////////////////////////////////////////

    // Idle workers can take an issue, held workers wait for the merger
    typedef enum logic [1:0] {
        W_IDLE = 2'd0,
        W_BUSY = 2'd1,
        W_HELD = 2'd2
    } worker_state_t;

endpackage

`default_nettype wire

//--- hdl/rx_hp_in_queue.sv
/*
 * Circular descriptor queue, QUEUE_DEPTH must be a power of two
 * A write while in_full is high is dropped
 */

`timescale 1ns/1ps
`default_nettype none

module rx_hp_in_queue import rx_hp_pkg::*; #(
    parameter int QUEUE_DEPTH = 8,
    parameter int WORKERS     = 4
) (
    input  logic               cclk,
    input  logic               i_sreset,
    input  logic               in_v,
    input  tag_t               in_tag,
    input  logic [WORKERS-1:0] in_dest,
    input  len_t               in_len,
    output logic               in_full,
    output logic               tc_v,
    output tag_t               tc_tag,
    output logic [WORKERS-1:0] tc_dest,
    output len_t               tc_len,
    input  logic               tc_pop
);

    localparam int PW = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
    localparam int CW = $clog2(QUEUE_DEPTH + 1);

    // Payload storage, only the pointers and count carry reset
    tag_t               q_tag  [QUEUE_DEPTH];
    logic [WORKERS-1:0] q_dest [QUEUE_DEPTH];
    len_t               q_len  [QUEUE_DEPTH];

    logic [PW-1:0] wr_ptr;
    logic [PW-1:0] rd_ptr;
    logic [CW-1:0] count;
    logic [CW-1:0] count_nxt;
    logic          do_wr;
    logic          do_pop;

    // Writes past full are dropped here
    assign do_wr  = in_v & ~in_full;
    assign do_pop = tc_pop & tc_v;

    always_comb begin
        count_nxt = count;
        if (do_wr && !do_pop) begin
            count_nxt = count + 1'b1;
        end else if (!do_wr && do_pop) begin
            count_nxt = count - 1'b1;
        end
    end

    always_ff @(posedge cclk) begin
        if (i_sreset) begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            count   <= '0;
            in_full <= 1'b0;
        end else begin
            // Pointers wrap naturally since the depth is a power of two
            if (do_wr) wr_ptr <= wr_ptr + 1'b1;
            if (do_pop) rd_ptr <= rd_ptr + 1'b1;
            count   <= count_nxt;
            in_full <= (count_nxt == CW'(QUEUE_DEPTH));
        end
    end

    always_ff @(posedge cclk) begin
        if (do_wr) begin
            q_tag[wr_ptr]  <= in_tag;
            q_dest[wr_ptr] <= in_dest;
            q_len[wr_ptr]  <= in_len;
        end
    end

    // Head descriptor is presented as a level while anything is stored
    assign tc_v    = (count != '0);
    assign tc_tag  = q_tag[rd_ptr];
    assign tc_dest = q_dest[rd_ptr];
    assign tc_len  = q_len[rd_ptr];

endmodule

`default_nettype wire

//--- hdl/rx_hp_age_arb.sv
/*
 * Age-ordered issue window, the oldest entry with a free allowed worker goes first
 * An entry with a zero destination mask would never issue
 */

`timescale 1ns/1ps
`default_nettype none

module rx_hp_age_arb import rx_hp_pkg::*; #(
    parameter int ARB_DEPTH = 4,
    parameter int WORKERS   = 4
) (
    input  logic               cclk,
    input  logic               i_sreset,
    input  logic               tc_v,
    input  tag_t               tc_tag,
    input  logic [WORKERS-1:0] tc_dest,
    input  len_t               tc_len,
    output logic               tc_pop,
    input  logic [WORKERS-1:0] free_worker,
    input  logic               issue_ready,
    output logic [WORKERS-1:0] issue_worker,
    output tag_t               issue_tag,
    output len_t               issue_len
);

    localparam int RW = (ARB_DEPTH > 1) ? $clog2(ARB_DEPTH) : 1;
    localparam int CW = $clog2(ARB_DEPTH + 1);

    logic [ARB_DEPTH-1:0] e_valid;
    tag_t                 e_tag  [ARB_DEPTH];
    logic [WORKERS-1:0]   e_dest [ARB_DEPTH];
    len_t                 e_len  [ARB_DEPTH];
    // Rank counts the older valid entries, so rank 0 is the oldest
    logic [RW-1:0]        e_rank [ARB_DEPTH];

    logic [ARB_DEPTH-1:0] new_slot;
    logic [ARB_DEPTH-1:0] admit;
    logic [ARB_DEPTH-1:0] entry_ready;
    logic [ARB_DEPTH-1:0] best_entry;
    logic [ARB_DEPTH-1:0] sel_entry;
    logic                 best_found;
    logic [RW-1:0]        best_rank;
    logic [RW-1:0]        sel_rank;
    logic [CW-1:0]        stay_cnt;
    logic [WORKERS-1:0]   sel_dest;
    logic [WORKERS-1:0]   avail;

    //////////////////////////////////////////////////////////////
    // Admission
    //////////////////////////////////////////////////////////////

    // Lowest empty slot takes the next head descriptor
    always_comb begin
        new_slot = '0;
        for (int i = ARB_DEPTH - 1; i >= 0; i--) begin
            if (!e_valid[i]) new_slot = ARB_DEPTH'(1) << i;
        end
    end

    // Pop only against a slot that is empty now, not one freed by this cycle's issue
    assign tc_pop = tc_v & (|new_slot);
    assign admit  = new_slot & {ARB_DEPTH{tc_pop}};

    // Entries that survive this cycle set the rank of the new one
    always_comb begin
        stay_cnt = '0;
        for (int i = 0; i < ARB_DEPTH; i++) begin
            stay_cnt = stay_cnt + CW'(e_valid[i] & ~sel_entry[i]);
        end
    end

    //////////////////////////////////////////////////////////////
    // Selection
    //////////////////////////////////////////////////////////////

    // An entry can go once any worker in its mask is idle
    always_comb begin
        for (int i = 0; i < ARB_DEPTH; i++) begin
            entry_ready[i] = e_valid[i] & (|(e_dest[i] & free_worker));
        end
    end

    // Ranks are unique among valid entries, so the minimum is a single slot
    always_comb begin
        best_entry = '0;
        best_found = 1'b0;
        best_rank  = '0;
        for (int i = 0; i < ARB_DEPTH; i++) begin
            if (entry_ready[i] && (!best_found || e_rank[i] < best_rank)) begin
                best_entry    = '0;
                best_entry[i] = 1'b1;
                best_found    = 1'b1;
                best_rank     = e_rank[i];
            end
        end
    end

    // Nothing leaves the window while issue_ready is low
    assign sel_entry = best_entry & {ARB_DEPTH{issue_ready}};
    assign sel_rank  = best_rank;

    //////////////////////////////////////////////////////////////
    // Issue
    //////////////////////////////////////////////////////////////

    // One-hot select, so an OR of masked fields is the mux
    always_comb begin
        issue_tag = '0;
        issue_len = '0;
        sel_dest  = '0;
        for (int i = 0; i < ARB_DEPTH; i++) begin
            issue_tag = issue_tag | (e_tag[i] & {$bits(tag_t){sel_entry[i]}});
            issue_len = issue_len | (e_len[i] & {$bits(len_t){sel_entry[i]}});
            sel_dest  = sel_dest | (e_dest[i] & {WORKERS{sel_entry[i]}});
        end
    end

    // Lowest free worker in the mask, zero when nothing is selected
    assign avail        = sel_dest & free_worker;
    assign issue_worker = avail & (~avail + WORKERS'(1));

    //////////////////////////////////////////////////////////////
    // Window state
    //////////////////////////////////////////////////////////////

    always_ff @(posedge cclk) begin
        if (i_sreset) begin
            e_valid <= '0;
        end else begin
            e_valid <= (e_valid & ~sel_entry) | admit;
        end
    end

    always_ff @(posedge cclk) begin
        for (int i = 0; i < ARB_DEPTH; i++) begin
            if (admit[i]) begin
                e_tag[i]  <= tc_tag;
                e_dest[i] <= tc_dest;
                e_len[i]  <= tc_len;
                e_rank[i] <= RW'(stay_cnt);
            end else if ((|sel_entry) && e_rank[i] > sel_rank) begin
                // Younger entries move up one place when an older one issues
                e_rank[i] <= e_rank[i] - 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- hdl/rx_hp_worker.sv
/*
 * One header worker, busy for len+1 cycles after issue, then holds its tag
 * until the merger pops it
 */

`timescale 1ns/1ps
`default_nettype none

module rx_hp_worker import rx_hp_pkg::*; (
    input  logic cclk,
    input  logic i_sreset,
    input  logic issue,
    input  tag_t issue_tag,
    input  len_t issue_len,
    output logic free_worker,
    output logic res_v,
    output tag_t res_tag,
    input  logic res_pop
);

    worker_state_t state;
    len_t          cnt;

    always_ff @(posedge cclk) begin
        if (i_sreset) begin
            state <= W_IDLE;
            cnt   <= '0;
        end else begin
            case (state)
                W_IDLE: begin
                    if (issue) begin
                        state <= W_BUSY;
                        cnt   <= issue_len;
                    end
                end
                W_BUSY: begin
                    // Zero count marks the last busy cycle
                    if (cnt == '0) begin
                        state <= W_HELD;
                    end else begin
                        cnt <= cnt - 1'b1;
                    end
                end
                W_HELD: begin
                    if (res_pop) state <= W_IDLE;
                end
                default: state <= W_IDLE;
            endcase
        end
    end

    // Tag is payload and only loads on an accepted issue
    always_ff @(posedge cclk) begin
        if (issue && state == W_IDLE) res_tag <= issue_tag;
    end

    assign free_worker = (state == W_IDLE);
    assign res_v       = (state == W_HELD);

endmodule

`default_nettype wire

//--- hdl/rx_hp_done_merge.sv
/*
 * Fixed-priority completion merger, lowest-indexed held worker drains first
 * A busy low worker can starve higher ones only while it keeps completing
 */

`timescale 1ns/1ps
`default_nettype none

module rx_hp_done_merge import rx_hp_pkg::*; #(
    parameter int WORKERS = 4
) (
    input  logic                                       cclk,
    input  logic                                       i_sreset,
    input  logic [WORKERS-1:0]                         res_v,
    input  tag_t [WORKERS-1:0]                         res_tag,
    output logic [WORKERS-1:0]                         res_pop,
    output logic                                       out_v,
    output tag_t                                       out_tag,
    output logic [$clog2(WORKERS > 1 ? WORKERS : 2)-1:0] out_worker
);

    localparam int WW = $clog2(WORKERS > 1 ? WORKERS : 2);

    tag_t          pick_tag;
    logic [WW-1:0] pick_idx;

    // Lowest set bit of the held vector is the one popped
    assign res_pop = res_v & (~res_v + WORKERS'(1));

    always_comb begin
        pick_tag = '0;
        pick_idx = '0;
        for (int i = 0; i < WORKERS; i++) begin
            if (res_pop[i]) begin
                pick_tag = res_tag[i];
                pick_idx = WW'(i);
            end
        end
    end

    always_ff @(posedge cclk) begin
        if (i_sreset) begin
            out_v <= 1'b0;
        end else begin
            out_v <= |res_v;
        end
    end

    // Tag and index are payload, qualified by out_v
    always_ff @(posedge cclk) begin
        out_tag    <= pick_tag;
        out_worker <= pick_idx;
    end

endmodule

`default_nettype wire

//--- hdl/rx_hp_top.sv
/*
 * Receive header scheduler, issue_ready low holds all issues
 * in_dest must be nonzero and writes with in_full high are dropped
 */

`timescale 1ns/1ps
`default_nettype none

module rx_hp_top import rx_hp_pkg::*; #(
    parameter int WORKERS     = 4,
    parameter int QUEUE_DEPTH = 8,
    parameter int ARB_DEPTH   = 4
) (
    input  logic                                       cclk,
    input  logic                                       i_sreset,
    input  logic                                       in_v,
    input  tag_t                                       in_tag,
    input  logic [WORKERS-1:0]                         in_dest,
    input  len_t                                       in_len,
    input  logic                                       issue_ready,
    output logic                                       in_full,
    output logic                                       out_v,
    output tag_t                                       out_tag,
    output logic [$clog2(WORKERS > 1 ? WORKERS : 2)-1:0] out_worker
);

    logic               tc_v;
    tag_t               tc_tag;
    logic [WORKERS-1:0] tc_dest;
    len_t               tc_len;
    logic               tc_pop;
    logic [WORKERS-1:0] free_worker;
    logic [WORKERS-1:0] issue_worker;
    tag_t               issue_tag;
    len_t               issue_len;
    logic [WORKERS-1:0] res_v;
    tag_t [WORKERS-1:0] res_tag;
    logic [WORKERS-1:0] res_pop;

    rx_hp_in_queue #(
        .QUEUE_DEPTH (QUEUE_DEPTH),
        .WORKERS     (WORKERS)
    ) u_in_queue (
        .cclk     (cclk),
        .i_sreset (i_sreset),
        .in_v     (in_v),
        .in_tag   (in_tag),
        .in_dest  (in_dest),
        .in_len   (in_len),
        .in_full  (in_full),
        .tc_v     (tc_v),
        .tc_tag   (tc_tag),
        .tc_dest  (tc_dest),
        .tc_len   (tc_len),
        .tc_pop   (tc_pop)
    );

    rx_hp_age_arb #(
        .ARB_DEPTH (ARB_DEPTH),
        .WORKERS   (WORKERS)
    ) u_age_arb (
        .cclk         (cclk),
        .i_sreset     (i_sreset),
        .tc_v         (tc_v),
        .tc_tag       (tc_tag),
        .tc_dest      (tc_dest),
        .tc_len       (tc_len),
        .tc_pop       (tc_pop),
        .free_worker  (free_worker),
        .issue_ready  (issue_ready),
        .issue_worker (issue_worker),
        .issue_tag    (issue_tag),
        .issue_len    (issue_len)
    );

    // Identical workers share the issue fields, each one takes its own one-hot bit
    for (genvar g = 0; g < WORKERS; g++) begin : g_worker
        rx_hp_worker u_worker (
            .cclk        (cclk),
            .i_sreset    (i_sreset),
            .issue       (issue_worker[g]),
            .issue_tag   (issue_tag),
            .issue_len   (issue_len),
            .free_worker (free_worker[g]),
            .res_v       (res_v[g]),
            .res_tag     (res_tag[g]),
            .res_pop     (res_pop[g])
        );
    end

    rx_hp_done_merge #(
        .WORKERS (WORKERS)
    ) u_done_merge (
        .cclk       (cclk),
        .i_sreset   (i_sreset),
        .res_v      (res_v),
        .res_tag    (res_tag),
        .res_pop    (res_pop),
        .out_v      (out_v),
        .out_tag    (out_tag),
        .out_worker (out_worker)
    );

endmodule

`default_nettype wire

//--- bench/rx_hp_assert.sv
/*
 * Concurrent checks bound into rx_hp_top for reset values, issue and drain rules
 */

`timescale 1ns/1ps
`default_nettype none

module rx_hp_assert #(
    parameter int WORKERS = 4
) (
    input logic               cclk,
    input logic               i_sreset,
    input logic               issue_ready,
    input logic               in_full,
    input logic               out_v,
    input logic               tc_v,
    input logic               tc_pop,
    input logic [WORKERS-1:0] free_worker,
    input logic [WORKERS-1:0] issue_worker,
    input logic [WORKERS-1:0] res_v,
    input logic [WORKERS-1:0] res_pop
);

    // Number of failed assertions so far
    int fail_cnt = 0;

    // All strobes low and every worker idle once reset has been applied
    reset_clears: assert property (@(posedge cclk) i_sreset |=> !out_v && !in_full && !tc_pop
                                   && issue_worker == '0 && res_pop == '0 && &free_worker)
        else begin
            $error("outputs or worker state not cleared after reset");
            fail_cnt++;
        end

    // One issue at most, only to an idle worker and only while issue_ready is high
    issue_legal: assert property (@(posedge cclk) disable iff (i_sreset)
        $onehot0(issue_worker) && (issue_worker & ~free_worker) == '0
        && (issue_ready || issue_worker == '0))
        else begin
            $error("illegal issue vector");
            fail_cnt++;
        end

    pop_legal: assert property (@(posedge cclk) disable iff (i_sreset)
        $onehot0(res_pop) && (res_pop & ~res_v) == '0 && (!tc_pop || tc_v))
        else begin
            $error("pop without a held result or queue entry");
            fail_cnt++;
        end

    // Each merger pop gives exactly one out_v pulse on the next cycle
    out_follows_pop: assert property (@(posedge cclk) disable iff (i_sreset)
        out_v == $past(|res_pop))
        else begin
            $error("out_v does not follow a merger pop");
            fail_cnt++;
        end

endmodule

bind rx_hp_top rx_hp_assert #(
    .WORKERS (WORKERS)
) u_assert (
    .cclk         (cclk),
    .i_sreset     (i_sreset),
    .issue_ready  (issue_ready),
    .in_full      (in_full),
    .out_v        (out_v),
    .tc_v         (tc_v),
    .tc_pop       (tc_pop),
    .free_worker  (free_worker),
    .issue_worker (issue_worker),
    .res_v        (res_v),
    .res_pop      (res_pop)
);

`default_nettype wire

//--- bench/rx_hp_tb.sv
/*
 * Testbench for rx_hp_top with WORKERS=4, tags stay unique across the whole run
 * Output checks run at the falling edge, stimulus moves 1 ns after the rising edge
 */

`timescale 1ns/1ps
`default_nettype none

module rx_hp_tb import rx_hp_pkg::*; ();

    localparam int WORKERS     = 4;
    localparam int QUEUE_DEPTH = 8;
    localparam int ARB_DEPTH   = 4;
    // Six tests with at most ~150 descriptors, worst case ~17 cycles each, plus margin
    localparam int MAX_CYCLES  = 4000;

    logic       cclk = 1'b0;
    logic       i_sreset;
    logic       in_v;
    tag_t       in_tag;
    logic [3:0] in_dest;
    len_t       in_len;
    logic       issue_ready;
    logic       in_full;
    logic       out_v;
    tag_t       out_tag;
    logic [1:0] out_worker;

    // Scoreboard indexed by tag
    logic [3:0] sb_mask [256];
    logic       sb_pending [256];
    int         sb_seq [256];

    integer seed = 32'h8e0cde1c;
    int     cycles;
    int     checks;
    int     errors;
    int     done_cnt;
    int     pend_cnt;
    int     wr_seq;
    int     last_seq;
    int     tests_run;
    int     tests_failed;
    int     cat_errs [7];
    logic   quiet_chk;
    logic   hold_chk;
    logic   order_chk;

    rx_hp_top #(
        .WORKERS     (WORKERS),
        .QUEUE_DEPTH (QUEUE_DEPTH),
        .ARB_DEPTH   (ARB_DEPTH)
    ) u_dut (
        .cclk        (cclk),
        .i_sreset    (i_sreset),
        .in_v        (in_v),
        .in_tag      (in_tag),
        .in_dest     (in_dest),
        .in_len      (in_len),
        .issue_ready (issue_ready),
        .in_full     (in_full),
        .out_v       (out_v),
        .out_tag     (out_tag),
        .out_worker  (out_worker)
    );

    always #4 cclk = ~cclk;

    // Run limit
    always @(posedge cclk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout after %0d cycles, %0d descriptors never completed", cycles, pend_cnt);
            $display("Something failed");
            $finish;
        end
    end

    task automatic report_error(input int cat, input string msg);
        $display("FAIL %0t: %s", $time, msg);
        errors++;
        cat_errs[cat]++;
    endtask

    ////////////////////////////////////////////////////////////
    // Output monitor
    ////////////////////////////////////////////////////////////

    always @(negedge cclk) begin
        if (!i_sreset) begin
            assert (!(quiet_chk && (out_v || in_full)))
                else report_error(1, "out_v or in_full high before the first write");
            assert (!(hold_chk && out_v))
                else report_error(5, $sformatf("tag %0d completed with issue held", out_tag));
            if (out_v) begin
                checks++;
                assert (sb_pending[out_tag])
                    else report_error(2, $sformatf("tag %0d was not pending", out_tag));
                assert (sb_mask[out_tag][out_worker])
                    else report_error(3, $sformatf("tag %0d on worker %0d, mask %b",
                                                   out_tag, out_worker, sb_mask[out_tag]));
                // A single allowed worker has to finish tags in write order
                if (order_chk) begin
                    assert (sb_seq[out_tag] > last_seq)
                        else report_error(4, $sformatf("tag %0d completed out of order", out_tag));
                    last_seq = sb_seq[out_tag];
                end
                if (sb_pending[out_tag]) pend_cnt--;
                sb_pending[out_tag] = 1'b0;
                done_cnt++;
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Stimulus helpers
    ////////////////////////////////////////////////////////////

    // Holds in_v for one edge and records the descriptor as pending
    task automatic drive_write(input tag_t t, input logic [3:0] m, input len_t l);
        in_v            = 1'b1;
        in_tag          = t;
        in_dest         = m;
        in_len          = l;
        sb_mask[t]      = m;
        sb_pending[t]   = 1'b1;
        sb_seq[t]       = wr_seq;
        wr_seq++;
        pend_cnt++;
        @(posedge cclk);
        #1;
        in_v = 1'b0;
    endtask

    task automatic send_desc(input tag_t t, input logic [3:0] m, input len_t l);
        while (in_full) begin
            @(posedge cclk);
            #1;
        end
        drive_write(t, m, l);
    endtask

    // Random nonzero mask and random length
    task automatic send_random(input tag_t t);
        logic [31:0] r;
        r = $random(seed);
        send_desc(t, (r[3:0] == 4'h0) ? 4'hf : r[3:0], r[7:4]);
    endtask

    task automatic wait_drain();
        while (pend_cnt != 0) begin
            @(posedge cclk);
            #1;
        end
    endtask

    task automatic end_test(input int n, input string name);
        tests_run++;
        if (cat_errs[n] == 0) begin
            $display("test %0d %s: passed", n, name);
        end else begin
            $display("test %0d %s: %0d errors", n, name, cat_errs[n]);
            tests_failed++;
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////////////////////////

    initial begin
        int acc;
        int done_base;
        logic saw_full;
        cycles = 0;
        checks = 0;
        errors = 0;
        done_cnt = 0;
        pend_cnt = 0;
        wr_seq = 0;
        last_seq = -1;
        tests_run = 0;
        tests_failed = 0;
        quiet_chk = 1'b0;
        hold_chk = 1'b0;
        order_chk = 1'b0;
        for (int i = 0; i < 7; i++) cat_errs[i] = 0;
        for (int i = 0; i < 256; i++) begin
            sb_mask[i]    = 4'h0;
            sb_pending[i] = 1'b0;
            sb_seq[i]     = 0;
        end
        i_sreset    = 1'b1;
        in_v        = 1'b0;
        in_tag      = '0;
        in_dest     = 4'h1;
        in_len      = '0;
        issue_ready = 1'b1;
        repeat (16) @(posedge cclk);
        #1;
        i_sreset  = 1'b0;
        quiet_chk = 1'b1;

        // Idle period with nothing written
        repeat (10) @(posedge cclk);
        #1;
        quiet_chk = 1'b0;
        end_test(1, "reset");

        // Random traffic, each tag must come back once on an allowed worker
        // A tag that never returns keeps pend_cnt above zero until the run limit
        for (int i = 0; i < 120; i++) send_random(tag_t'(i));
        wait_drain();
        end_test(2, "every tag once");
        end_test(3, "destination");

        // Burst restricted to worker 2
        order_chk = 1'b1;
        for (int i = 0; i < 12; i++) send_desc(tag_t'(120 + i), 4'b0100, len_t'($random(seed)));
        wait_drain();
        order_chk = 1'b0;
        end_test(4, "age order");

        // Nothing may complete while issue is held
        issue_ready = 1'b0;
        for (int i = 0; i < 6; i++) send_random(tag_t'(140 + i));
        hold_chk = 1'b1;
        repeat (20) @(posedge cclk);
        #1;
        hold_chk    = 1'b0;
        issue_ready = 1'b1;
        wait_drain();
        end_test(5, "issue hold");

        // Queue plus window fill up, then everything accepted drains
        issue_ready = 1'b0;
        acc         = 0;
        saw_full    = 1'b0;
        done_base   = done_cnt;
        for (int i = 0; i < QUEUE_DEPTH + ARB_DEPTH + 4; i++) begin
            if (in_full) begin
                saw_full = 1'b1;
                @(posedge cclk);
                #1;
            end else begin
                send_random(tag_t'(160 + acc));
                acc++;
            end
        end
        assert (saw_full || in_full) else report_error(6, "in_full never rose under back-pressure");
        issue_ready = 1'b1;
        wait_drain();
        assert (done_cnt - done_base == acc)
            else report_error(6, $sformatf("%0d accepted but %0d completed",
                                           acc, done_cnt - done_base));
        end_test(6, "back-pressure");

        errors += u_dut.u_assert.fail_cnt;
        $display("Tests run %0d, tests with errors %0d, completions checked %0d, errors %0d",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- flist.f
hdl/rx_hp_pkg.sv
hdl/rx_hp_in_queue.sv
hdl/rx_hp_age_arb.sv
hdl/rx_hp_worker.sv
hdl/rx_hp_done_merge.sv
hdl/rx_hp_top.sv
bench/rx_hp_assert.sv
bench/rx_hp_tb.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the receive header scheduler testbench with Verilator
set -e
cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module rx_hp_tb -f flist.f -o rx_hp_sim

# The log decides pass or fail, so the simulator status is not checked here
./obj_dir/rx_hp_sim +verilator+error+limit+1000 | tee "$LOG"

if grep -qx "Everything OK" "$LOG"; then
    echo "Simulation passed"
    exit 0
else
    echo "Simulation did not pass, see $LOG"
    exit 1
fi
